/* Makefile */
TOP := tb_cache_mem_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cache_mem_subsystem.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* cache_mem_subsystem.f */
hw/cache_mem_pkg.sv
hw/refill_read_arbiter.sv
hw/wbuf_write_channel.sv
hw/cache_mem_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_cache_mem_subsystem.sv

/* hw/cache_mem_pkg.sv */
`default_nettype none

package cache_mem_pkg;

  // Default bus widths, overridden through the top level parameters
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;

  localparam int AXI_RESP_W = 2;

  typedef logic [AXI_RESP_W-1:0] axi_resp_t;

  // Anything other than OKAY is treated as an error
  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA,
    RD_RESP
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SEND,
    WR_WAIT_B,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    SRC_ICACHE,
    SRC_DCACHE
  } rd_src_e;

endpackage : cache_mem_pkg

`default_nettype wire

/* hw/cache_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_mem_subsystem #(
  parameter int AddrWidth = cache_mem_pkg::ADDR_W,
  parameter int DataWidth = cache_mem_pkg::DATA_W
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,

  // Instruction refill
  input  wire logic                     icache_req_valid_i,
  output logic                          icache_req_ready_o,
  input  wire logic [AddrWidth-1:0]     icache_req_addr_i,
  output logic                          icache_rsp_valid_o,

  // Data refill
  input  wire logic                     dcache_req_valid_i,
  output logic                          dcache_req_ready_o,
  input  wire logic [AddrWidth-1:0]     dcache_req_addr_i,
  output logic                          dcache_rsp_valid_o,

  // Shared refill response
  output logic      [DataWidth-1:0]     refill_rsp_data_o,
  output logic                          refill_rsp_err_o,

  // Write buffer
  input  wire logic                     wbuf_req_valid_i,
  output logic                          wbuf_req_ready_o,
  input  wire logic [AddrWidth-1:0]     wbuf_req_addr_i,
  input  wire logic [DataWidth-1:0]     wbuf_req_data_i,
  input  wire logic [DataWidth/8-1:0]   wbuf_req_strb_i,
  output logic                          wbuf_rsp_valid_o,
  output logic                          wbuf_rsp_err_o,

  // Flush and status
  input  wire logic                     flush_i,
  output logic                          flush_ack_o,
  output logic                          wbuf_empty_o,

  // AXI4-Lite master
  output logic      [AddrWidth-1:0]     m_axi_araddr_o,
  output logic                          m_axi_arvalid_o,
  input  wire logic                     m_axi_arready_i,
  input  wire logic [DataWidth-1:0]     m_axi_rdata_i,
  input  wire cache_mem_pkg::axi_resp_t m_axi_rresp_i,
  input  wire logic                     m_axi_rvalid_i,
  output logic                          m_axi_rready_o,
  output logic      [AddrWidth-1:0]     m_axi_awaddr_o,
  output logic                          m_axi_awvalid_o,
  input  wire logic                     m_axi_awready_i,
  output logic      [DataWidth-1:0]     m_axi_wdata_o,
  output logic      [DataWidth/8-1:0]   m_axi_wstrb_o,
  output logic                          m_axi_wvalid_o,
  input  wire logic                     m_axi_wready_i,
  input  wire cache_mem_pkg::axi_resp_t m_axi_bresp_i,
  input  wire logic                     m_axi_bvalid_i,
  output logic                          m_axi_bready_o
);

  // Refill reads share AR and R
  refill_read_arbiter #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) i_refill_read_arbiter (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .icache_req_valid_i (icache_req_valid_i),
    .icache_req_ready_o (icache_req_ready_o),
    .icache_req_addr_i  (icache_req_addr_i),
    .icache_rsp_valid_o (icache_rsp_valid_o),
    .dcache_req_valid_i (dcache_req_valid_i),
    .dcache_req_ready_o (dcache_req_ready_o),
    .dcache_req_addr_i  (dcache_req_addr_i),
    .dcache_rsp_valid_o (dcache_rsp_valid_o),
    .refill_rsp_data_o  (refill_rsp_data_o),
    .refill_rsp_err_o   (refill_rsp_err_o),
    .m_axi_araddr_o     (m_axi_araddr_o),
    .m_axi_arvalid_o    (m_axi_arvalid_o),
    .m_axi_arready_i    (m_axi_arready_i),
    .m_axi_rdata_i      (m_axi_rdata_i),
    .m_axi_rresp_i      (m_axi_rresp_i),
    .m_axi_rvalid_i     (m_axi_rvalid_i),
    .m_axi_rready_o     (m_axi_rready_o)
  );

  // Write buffer drain runs alongside the reads
  wbuf_write_channel #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) i_wbuf_write_channel (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .wbuf_req_valid_i (wbuf_req_valid_i),
    .wbuf_req_ready_o (wbuf_req_ready_o),
    .wbuf_req_addr_i  (wbuf_req_addr_i),
    .wbuf_req_data_i  (wbuf_req_data_i),
    .wbuf_req_strb_i  (wbuf_req_strb_i),
    .wbuf_rsp_valid_o (wbuf_rsp_valid_o),
    .wbuf_rsp_err_o   (wbuf_rsp_err_o),
    .flush_i          (flush_i),
    .flush_ack_o      (flush_ack_o),
    .wbuf_empty_o     (wbuf_empty_o),
    .m_axi_awaddr_o   (m_axi_awaddr_o),
    .m_axi_awvalid_o  (m_axi_awvalid_o),
    .m_axi_awready_i  (m_axi_awready_i),
    .m_axi_wdata_o    (m_axi_wdata_o),
    .m_axi_wstrb_o    (m_axi_wstrb_o),
    .m_axi_wvalid_o   (m_axi_wvalid_o),
    .m_axi_wready_i   (m_axi_wready_i),
    .m_axi_bresp_i    (m_axi_bresp_i),
    .m_axi_bvalid_i   (m_axi_bvalid_i),
    .m_axi_bready_o   (m_axi_bready_o)
  );

endmodule : cache_mem_subsystem

`default_nettype wire

/* hw/refill_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_read_arbiter #(
  parameter int AddrWidth = cache_mem_pkg::ADDR_W,
  parameter int DataWidth = cache_mem_pkg::DATA_W
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,

  // Instruction cache refill
  input  wire logic                     icache_req_valid_i,
  output logic                          icache_req_ready_o,
  input  wire logic [AddrWidth-1:0]     icache_req_addr_i,
  output logic                          icache_rsp_valid_o,

  // Data cache miss
  input  wire logic                     dcache_req_valid_i,
  output logic                          dcache_req_ready_o,
  input  wire logic [AddrWidth-1:0]     dcache_req_addr_i,
  output logic                          dcache_rsp_valid_o,

  // Shared refill response
  output logic      [DataWidth-1:0]     refill_rsp_data_o,
  output logic                          refill_rsp_err_o,

  // AXI4-Lite AR and R
  output logic      [AddrWidth-1:0]     m_axi_araddr_o,
  output logic                          m_axi_arvalid_o,
  input  wire logic                     m_axi_arready_i,
  input  wire logic [DataWidth-1:0]     m_axi_rdata_i,
  input  wire cache_mem_pkg::axi_resp_t m_axi_rresp_i,
  input  wire logic                     m_axi_rvalid_i,
  output logic                          m_axi_rready_o
);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  cache_mem_pkg::rd_state_e state_q;
  cache_mem_pkg::rd_state_e state_d;
  cache_mem_pkg::rd_src_e   src_q;

  addr_t addr_q;
  data_t data_q;
  logic  err_q;

  logic  icache_accept;
  logic  dcache_accept;
  logic  r_fire;
  logic  rd_idle;

  ////////////////////////////////////////////////////////////////////////////
  // Request arbitration
  ////////////////////////////////////////////////////////////////////////////

  assign rd_idle = (state_q == cache_mem_pkg::RD_IDLE);

  // Fixed priority, instruction cache first
  assign icache_req_ready_o = rd_idle;
  assign dcache_req_ready_o = rd_idle && !icache_req_valid_i;

  assign icache_accept = icache_req_valid_i && icache_req_ready_o;
  assign dcache_accept = dcache_req_valid_i && dcache_req_ready_o;

  assign r_fire = m_axi_rvalid_i && m_axi_rready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Read FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cache_mem_pkg::RD_IDLE: begin
        if (icache_accept || dcache_accept) begin
          state_d = cache_mem_pkg::RD_ADDR;
        end
      end
      cache_mem_pkg::RD_ADDR: begin
        if (m_axi_arready_i) begin
          state_d = cache_mem_pkg::RD_DATA;
        end
      end
      cache_mem_pkg::RD_DATA: begin
        if (m_axi_rvalid_i) begin
          state_d = cache_mem_pkg::RD_RESP;
        end
      end
      cache_mem_pkg::RD_RESP: begin
        state_d = cache_mem_pkg::RD_IDLE;
      end
      default: begin
        state_d = cache_mem_pkg::RD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= cache_mem_pkg::RD_IDLE;
      src_q   <= cache_mem_pkg::SRC_ICACHE;
    end else begin
      state_q <= state_d;
      // Remember who owns the read in flight
      if (icache_accept) begin
        src_q <= cache_mem_pkg::SRC_ICACHE;
      end else if (dcache_accept) begin
        src_q <= cache_mem_pkg::SRC_DCACHE;
      end
    end
  end

  // Address and read data
  always_ff @(posedge clk_i) begin
    if (icache_accept) begin
      addr_q <= icache_req_addr_i;
    end else if (dcache_accept) begin
      addr_q <= dcache_req_addr_i;
    end
    if (r_fire) begin
      data_q <= m_axi_rdata_i;
      err_q  <= (m_axi_rresp_i != cache_mem_pkg::AXI_RESP_OKAY);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign m_axi_araddr_o  = addr_q;
  assign m_axi_arvalid_o = (state_q == cache_mem_pkg::RD_ADDR);
  assign m_axi_rready_o  = (state_q == cache_mem_pkg::RD_DATA);

  // Response pulse goes to the owner only
  assign icache_rsp_valid_o = (state_q == cache_mem_pkg::RD_RESP) &&
                              (src_q == cache_mem_pkg::SRC_ICACHE);
  assign dcache_rsp_valid_o = (state_q == cache_mem_pkg::RD_RESP) &&
                              (src_q == cache_mem_pkg::SRC_DCACHE);

  assign refill_rsp_data_o = data_q;
  assign refill_rsp_err_o  = err_q;

endmodule : refill_read_arbiter

`default_nettype wire

/* hw/wbuf_write_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module wbuf_write_channel #(
  parameter int AddrWidth = cache_mem_pkg::ADDR_W,
  parameter int DataWidth = cache_mem_pkg::DATA_W
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,

  // Write buffer drain
  input  wire logic                     wbuf_req_valid_i,
  output logic                          wbuf_req_ready_o,
  input  wire logic [AddrWidth-1:0]     wbuf_req_addr_i,
  input  wire logic [DataWidth-1:0]     wbuf_req_data_i,
  input  wire logic [DataWidth/8-1:0]   wbuf_req_strb_i,
  output logic                          wbuf_rsp_valid_o,
  output logic                          wbuf_rsp_err_o,

  // Flush and status
  input  wire logic                     flush_i,
  output logic                          flush_ack_o,
  output logic                          wbuf_empty_o,

  // AXI4-Lite AW, W and B
  output logic      [AddrWidth-1:0]     m_axi_awaddr_o,
  output logic                          m_axi_awvalid_o,
  input  wire logic                     m_axi_awready_i,
  output logic      [DataWidth-1:0]     m_axi_wdata_o,
  output logic      [DataWidth/8-1:0]   m_axi_wstrb_o,
  output logic                          m_axi_wvalid_o,
  input  wire logic                     m_axi_wready_i,
  input  wire cache_mem_pkg::axi_resp_t m_axi_bresp_i,
  input  wire logic                     m_axi_bvalid_i,
  output logic                          m_axi_bready_o
);

  localparam int StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  cache_mem_pkg::wr_state_e state_q;
  cache_mem_pkg::wr_state_e state_d;

  addr_t addr_q;
  data_t data_q;
  strb_t strb_q;
  logic  err_q;

  logic  aw_done_q;
  logic  w_done_q;
  logic  flush_ack_q;

  logic  wbuf_accept;
  logic  aw_fire;
  logic  w_fire;
  logic  b_fire;
  logic  wr_idle;

  assign wr_idle     = (state_q == cache_mem_pkg::WR_IDLE);
  assign wbuf_accept = wbuf_req_valid_i && wr_idle;
  assign aw_fire     = m_axi_awvalid_o && m_axi_awready_i;
  assign w_fire      = m_axi_wvalid_o && m_axi_wready_i;
  assign b_fire      = m_axi_bvalid_i && m_axi_bready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Write FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cache_mem_pkg::WR_IDLE: begin
        if (wbuf_accept) begin
          state_d = cache_mem_pkg::WR_SEND;
        end
      end
      cache_mem_pkg::WR_SEND: begin
        // AW and W may complete in either order
        if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
          state_d = cache_mem_pkg::WR_WAIT_B;
        end
      end
      cache_mem_pkg::WR_WAIT_B: begin
        if (m_axi_bvalid_i) begin
          state_d = cache_mem_pkg::WR_RESP;
        end
      end
      cache_mem_pkg::WR_RESP: begin
        state_d = cache_mem_pkg::WR_IDLE;
      end
      default: begin
        state_d = cache_mem_pkg::WR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= cache_mem_pkg::WR_IDLE;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (wbuf_accept) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        aw_done_q <= aw_done_q | aw_fire;
        w_done_q  <= w_done_q | w_fire;
      end
      // Single cycle ack, only once the channel is drained
      flush_ack_q <= flush_i & ~flush_ack_q & (state_d == cache_mem_pkg::WR_IDLE);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wbuf_accept) begin
      addr_q <= wbuf_req_addr_i;
      data_q <= wbuf_req_data_i;
      strb_q <= wbuf_req_strb_i;
    end
    if (b_fire) begin
      err_q <= (m_axi_bresp_i != cache_mem_pkg::AXI_RESP_OKAY);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign wbuf_req_ready_o = wr_idle;
  assign wbuf_empty_o     = wr_idle;
  assign flush_ack_o      = flush_ack_q;

  assign m_axi_awaddr_o  = addr_q;
  assign m_axi_awvalid_o = (state_q == cache_mem_pkg::WR_SEND) && !aw_done_q;
  assign m_axi_wdata_o   = data_q;
  assign m_axi_wstrb_o   = strb_q;
  assign m_axi_wvalid_o  = (state_q == cache_mem_pkg::WR_SEND) && !w_done_q;
  assign m_axi_bready_o  = (state_q == cache_mem_pkg::WR_WAIT_B);

  assign wbuf_rsp_valid_o = (state_q == cache_mem_pkg::WR_RESP);
  assign wbuf_rsp_err_o   = err_q;

endmodule : wbuf_write_channel

`default_nettype wire

/* testbench/tb_cache_mem_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cache_mem_subsystem;

  localparam int AddrWidth     = 32;
  localparam int DataWidth     = 64;
  localparam int StrbWidth     = DataWidth / 8;
  localparam int MemDepth      = 256;
  localparam int TimeoutCycles = 200;

  logic clk;
  logic rst_n;

  logic icache_req_valid_i, icache_req_ready_o, icache_rsp_valid_o;
  logic dcache_req_valid_i, dcache_req_ready_o, dcache_rsp_valid_o;
  logic [AddrWidth-1:0] icache_req_addr_i, dcache_req_addr_i, wbuf_req_addr_i;
  logic [DataWidth-1:0] refill_rsp_data_o, wbuf_req_data_i;
  logic [StrbWidth-1:0] wbuf_req_strb_i, m_axi_wstrb_o;
  logic refill_rsp_err_o, wbuf_req_valid_i, wbuf_req_ready_o, wbuf_rsp_valid_o, wbuf_rsp_err_o;
  logic flush_i, flush_ack_o, wbuf_empty_o;
  logic [AddrWidth-1:0] m_axi_araddr_o, m_axi_awaddr_o;
  logic [DataWidth-1:0] m_axi_rdata_i, m_axi_wdata_o;
  logic [1:0] m_axi_rresp_i, m_axi_bresp_i;
  logic m_axi_arvalid_o, m_axi_arready_i, m_axi_rvalid_i, m_axi_rready_o;
  logic m_axi_awvalid_o, m_axi_awready_i, m_axi_wvalid_o, m_axi_wready_i;
  logic m_axi_bvalid_i, m_axi_bready_o;

  logic [DataWidth-1:0] mem [MemDepth];
  logic [DataWidth-1:0] shadow [MemDepth];
  logic [31:0] lcg_state = 32'h02a152bd;
  int mismatch_count = 0;
  int protocol_count = 0;
  int timeout_count = 0;
  bit rd_busy = 1'b0;
  bit wr_busy = 1'b0;

  tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(rst_n));

  cache_mem_subsystem #(
    .AddrWidth (AddrWidth),
    .DataWidth (DataWidth)
  ) UUT (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .*
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DataWidth-1:0] fill_word(input int idx);
    return DataWidth'(idx) * 64'h9e37_79b9_7f4a_7c15 + 64'd1;
  endfunction

  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_word,
      input logic [DataWidth-1:0] new_word, input logic [StrbWidth-1:0] strb);
    logic [DataWidth-1:0] res;
    res = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic print_counts();
    $display("Errors: %0d mismatches, %0d protocol, %0d timeouts",
             mismatch_count, protocol_count, timeout_count);
  endtask

  task automatic check_value(input string test, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch %s: expected %h, actual %h", test, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_cond(input string test, input logic cond, input string what);
    assert (cond) else begin
      $display("Error in %s: %s", test, what);
      protocol_count++;
    end
  endtask

  // One more clock of waiting, or give up
  task automatic step_or_abort(inout int n, input string what);
    @(posedge clk);
    n++;
    if (n == TimeoutCycles) begin
      timeout_count++;
      $display("Timeout waiting for %s", what);
      print_counts();
      $display("CHECKS FAILED");
      $finish;
    end
  endtask

  task automatic wait_accept(input string test, input bit from_dcache);
    int n;
    n = 0;
    @(posedge clk);
    while (!(from_dcache ? dcache_req_ready_o : icache_req_ready_o)) begin
      step_or_abort(n, {test, " read accept"});
    end
    @(negedge clk);
    if (from_dcache) begin
      dcache_req_valid_i = 1'b0;
    end else begin
      icache_req_valid_i = 1'b0;
    end
  endtask

  task automatic wait_response(input string test, input bit from_dcache,
                               output logic [DataWidth-1:0] data, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    while (!(from_dcache ? dcache_rsp_valid_o : icache_rsp_valid_o)) begin
      step_or_abort(n, {test, " read response"});
    end
    check_cond(test, !(from_dcache ? icache_rsp_valid_o : dcache_rsp_valid_o),
               "read response pulsed on the wrong port");
    data = refill_rsp_data_o;
    err  = refill_rsp_err_o;
  endtask

  task automatic read_word(input string test, input bit from_dcache,
                           input logic [AddrWidth-1:0] addr,
                           output logic [DataWidth-1:0] data, output logic err);
    @(negedge clk);
    if (from_dcache) begin
      dcache_req_valid_i = 1'b1;
      dcache_req_addr_i  = addr;
    end else begin
      icache_req_valid_i = 1'b1;
      icache_req_addr_i  = addr;
    end
    wait_accept(test, from_dcache);
    wait_response(test, from_dcache, data, err);
  endtask

  task automatic start_write(input string test, input logic [AddrWidth-1:0] addr,
                             input logic [DataWidth-1:0] data, input logic [StrbWidth-1:0] strb);
    int n;
    @(negedge clk);
    wbuf_req_valid_i = 1'b1;
    wbuf_req_addr_i  = addr;
    wbuf_req_data_i  = data;
    wbuf_req_strb_i  = strb;
    n = 0;
    @(posedge clk);
    while (!wbuf_req_ready_o) begin
      step_or_abort(n, {test, " write accept"});
    end
    @(negedge clk);
    wbuf_req_valid_i = 1'b0;
  endtask

  // No flush acknowledge may appear while the write is in flight
  task automatic wait_write_response(input string test, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    while (!wbuf_rsp_valid_o) begin
      check_cond(test, !flush_ack_o, "flush acknowledged with a write outstanding");
      step_or_abort(n, {test, " write response"});
    end
    check_cond(test, !flush_ack_o, "flush acknowledged with a write outstanding");
    err = wbuf_rsp_err_o;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // AXI4-Lite slave model
  ////////////////////////////////////////////////////////////////////////////

  initial begin : read_slave
    logic [AddrWidth-1:0] a;
    int n;
    m_axi_arready_i = 1'b0;
    m_axi_rvalid_i  = 1'b0;
    m_axi_rdata_i   = '0;
    m_axi_rresp_i   = 2'b00;
    forever begin
      @(negedge clk);
      if (m_axi_arvalid_o) begin
        a = m_axi_araddr_o;
        repeat (int'(next_rand() >> 30)) @(negedge clk);
        m_axi_arready_i = 1'b1;
        @(negedge clk);
        m_axi_arready_i = 1'b0;
        repeat (int'(next_rand() >> 30)) @(negedge clk);
        // Top address bit selects the error region
        m_axi_rvalid_i = 1'b1;
        m_axi_rresp_i  = a[31] ? 2'b10 : 2'b00;
        m_axi_rdata_i  = a[31] ? '0 : mem[a[10:3]];
        n = 0;
        @(posedge clk);
        while (!m_axi_rready_o) begin
          step_or_abort(n, "R handshake");
        end
        @(negedge clk);
        m_axi_rvalid_i = 1'b0;
      end
    end
  end

  initial begin : write_slave
    logic [AddrWidth-1:0] a;
    int n;
    m_axi_awready_i = 1'b0;
    m_axi_wready_i  = 1'b0;
    m_axi_bvalid_i  = 1'b0;
    m_axi_bresp_i   = 2'b00;
    for (int i = 0; i < MemDepth; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(negedge clk);
      if (m_axi_awvalid_o) begin
        a = m_axi_awaddr_o;
        repeat (int'(next_rand() >> 30)) @(negedge clk);
        m_axi_awready_i = 1'b1;
        @(negedge clk);
        m_axi_awready_i = 1'b0;
        repeat (int'(next_rand() >> 30)) @(negedge clk);
        m_axi_wready_i = 1'b1;
        n = 0;
        @(posedge clk);
        while (!m_axi_wvalid_o) begin
          step_or_abort(n, "W handshake");
        end
        if (!a[31]) begin
          mem[a[10:3]] = merge_bytes(mem[a[10:3]], m_axi_wdata_o, m_axi_wstrb_o);
        end
        @(negedge clk);
        m_axi_wready_i = 1'b0;
        repeat (int'(next_rand() >> 30)) @(negedge clk);
        m_axi_bvalid_i = 1'b1;
        m_axi_bresp_i  = a[31] ? 2'b10 : 2'b00;
        n = 0;
        @(posedge clk);
        while (!m_axi_bready_o) begin
          step_or_abort(n, "B handshake");
        end
        @(negedge clk);
        m_axi_bvalid_i = 1'b0;
      end
    end
  end

  // Outstanding transaction tracking per channel
  always @(posedge clk) begin
    if (rd_busy) begin
      check_cond("backpressure", !icache_req_ready_o && !dcache_req_ready_o,
                 "read request ready high with a read outstanding");
    end
    if (wr_busy) begin
      check_cond("backpressure", !wbuf_req_ready_o,
                 "write request ready high with a write outstanding");
    end
    if (icache_rsp_valid_o || dcache_rsp_valid_o) begin
      rd_busy = 1'b0;
    end
    if ((icache_req_valid_i && icache_req_ready_o) ||
        (dcache_req_valid_i && dcache_req_ready_o)) begin
      rd_busy = 1'b1;
    end
    if (wbuf_rsp_valid_o) begin
      wr_busy = 1'b0;
    end
    if (wbuf_req_valid_i && wbuf_req_ready_o) begin
      wr_busy = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [DataWidth-1:0] data;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] expected;
    logic [StrbWidth-1:0] strb;
    logic [AddrWidth-1:0] addr;
    logic [31:0] r;
    logic err;
    int n;

    icache_req_valid_i = 1'b0;
    icache_req_addr_i  = '0;
    dcache_req_valid_i = 1'b0;
    dcache_req_addr_i  = '0;
    wbuf_req_valid_i   = 1'b0;
    wbuf_req_addr_i    = '0;
    wbuf_req_data_i    = '0;
    wbuf_req_strb_i    = '0;
    flush_i            = 1'b0;
    for (int i = 0; i < MemDepth; i++) begin
      shadow[i] = fill_word(i);
    end

    n = 0;
    @(posedge clk);
    while (!rst_n) begin
      step_or_abort(n, "reset release");
    end
    @(negedge clk);
    check_cond("reset", icache_req_ready_o && dcache_req_ready_o && wbuf_req_ready_o &&
               wbuf_empty_o && !flush_ack_o && !m_axi_arvalid_o && !m_axi_awvalid_o &&
               !m_axi_wvalid_o && !m_axi_rready_o && !m_axi_bready_o &&
               !icache_rsp_valid_o && !dcache_rsp_valid_o && !wbuf_rsp_valid_o,
               "wrong output levels after reset");

    read_word("icache_refill", 1'b0, 32'h0000_0028, data, err);
    check_value("icache_refill", shadow[5], data);
    check_value("icache_refill", '0, DataWidth'(err));

    // Both readers on the same edge
    @(negedge clk);
    icache_req_valid_i = 1'b1;
    icache_req_addr_i  = 32'h0000_0010;
    dcache_req_valid_i = 1'b1;
    dcache_req_addr_i  = 32'h0000_0018;
    @(posedge clk);
    check_cond("refill_priority", icache_req_ready_o && !dcache_req_ready_o,
               "instruction cache did not win arbitration");
    @(negedge clk);
    icache_req_valid_i = 1'b0;
    wait_response("refill_priority", 1'b0, data, err);
    check_value("refill_priority", shadow[2], data);
    wait_accept("refill_priority", 1'b1);
    wait_response("refill_priority", 1'b1, data, err);
    check_value("refill_priority", shadow[3], data);

    wdata = {next_rand(), next_rand()};
    r = next_rand();
    strb = r[7:0];
    expected = merge_bytes(shadow[32], wdata, strb);
    start_write("strobed_write", 32'h0000_0100, wdata, strb);
    wait_write_response("strobed_write", err);
    check_value("strobed_write", '0, DataWidth'(err));
    shadow[32] = expected;
    read_word("strobed_write", 1'b1, 32'h0000_0100, data, err);
    check_value("strobed_write", expected, data);

    read_word("error_response", 1'b0, 32'h8000_0040, data, err);
    check_value("error_response", 1, DataWidth'(err));
    start_write("error_response", 32'h8000_0040, '1, '1);
    wait_write_response("error_response", err);
    check_value("error_response", 1, DataWidth'(err));
    read_word("error_response", 1'b1, 32'h0000_0040, data, err);
    check_value("error_response", shadow[8], data);
    check_value("error_response", '0, DataWidth'(err));

    // Random mix, one in eight hits the error region
    for (int i = 0; i < 30; i++) begin
      r = next_rand();
      addr = {r[2:0] == 3'd0, 20'd0, r[10:3], 3'd0};
      if (r[11]) begin
        wdata = {next_rand(), next_rand()};
        strb  = r[19:12];
        start_write("backpressure", addr, wdata, strb);
        wait_write_response("backpressure", err);
        if (!addr[31]) begin
          shadow[r[10:3]] = merge_bytes(shadow[r[10:3]], wdata, strb);
        end
      end else begin
        read_word("backpressure", r[12], addr, data, err);
        check_value("backpressure", addr[31] ? '0 : shadow[r[10:3]], data);
      end
      check_value("backpressure", DataWidth'(addr[31]), DataWidth'(err));
    end

    wdata = {next_rand(), next_rand()};
    start_write("flush_ack", 32'h0000_0080, wdata, '1);
    flush_i = 1'b1;
    wait_write_response("flush_ack", err);
    shadow[16] = wdata;
    for (int k = 0; k < 6; k++) begin
      @(posedge clk);
      check_value("flush_ack", DataWidth'(k % 2 == 0), DataWidth'(flush_ack_o));
      check_cond("flush_ack", wbuf_empty_o, "write buffer not empty after the drain");
    end
    @(negedge clk);
    flush_i = 1'b0;

    print_counts();
    if (mismatch_count + protocol_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_cache_mem_subsystem

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HalfPeriodNs = 5,
  parameter int ResetCycles  = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the flops
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule : tb_clock_gen

`default_nettype wire
